// ==== Bender.yml ====
package:
  name: capture_system

sources:
  - include_dirs:
      - logic
    files:
      - logic/sample_pkg.sv
      - logic/capture_ctrl_pkg.sv
      - logic/trigger_fsm.sv
      - logic/capture_timer.sv
      - logic/pretrigger_window.sv
      - logic/record_buffer.sv
      - logic/waveform_capture_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_waveform_capture.sv

// ==== capture_system.f ====
+incdir+logic
logic/sample_pkg.sv
logic/capture_ctrl_pkg.sv
logic/trigger_fsm.sv
logic/capture_timer.sv
logic/pretrigger_window.sv
logic/record_buffer.sv
logic/waveform_capture_top.sv
testbench/tb_clock_gen.sv
testbench/tb_waveform_capture.sv

// ==== logic/capture_ctrl_pkg.sv ====
package capture_ctrl_pkg;

    // capture sequencer states
    typedef enum logic [1:0] {
        IDLE,                                // watching channel a
        CAPTURE,                             // writing post samples
        STORE,                               // commit cycle
        FULL                                 // waiting for host clear
    } cap_state_e;

    // host command strobe
    typedef enum logic [1:0] {
        OP_NOP,
        OP_READ,
        OP_CLEAR
    } host_op_e;

    // host request, 11 bits
    typedef struct packed {
        host_op_e             op;
        sample_pkg::rec_idx_t record;        // record to read
        sample_pkg::word_idx_t word;         // word within record
    } host_req_t;

endpackage

// ==== logic/capture_macros.svh ====
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

////////////////////////////////////////////////////////////
// adc and word geometry
`define CAP_SAMPLE_W     14        // raw adc sample bits
`define CAP_WORD_W       32        // a in upper half, b in lower

////////////////////////////////////////////////////////////
// record layout
`define CAP_PRE_LEN      4         // samples kept before trigger
`define CAP_POST_LEN     28        // trigger sample plus 27 after
`define CAP_REC_WORDS    32        // pre + post
`define CAP_NUM_RECORDS  10        // buffer depth in records

// trigger on negative pulse, at or below this level
`define CAP_TRIG_LEVEL   (-2170)

// timestamp counter, wraps once a second at 50 MHz
`define CAP_TIME_W       26
`define CAP_TIMER_WRAP   50000000

`endif

// ==== logic/capture_timer.sv ====
`include "capture_macros.svh"

module capture_timer #(
    parameter int unsigned wrap_count = `CAP_TIMER_WRAP  // cycles per period
) (
    input  logic                ADA_DCO,
    input  logic                hps_fpga_reset_n,
    output sample_pkg::stamp_t  stamp,                  // current time
    output logic                heartbeat               // led level
);

    sample_pkg::stamp_t count;
    logic               wrap;
    logic               level;

    // last count of the period
    assign wrap = count == sample_pkg::stamp_t'(wrap_count - 1);

    ////////////////////////////////////////////////////////////
    // timebase, doubles as heartbeat divider
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            count <= '0;
            level <= 1'b0;
        end
        else if (wrap)
        begin
            count <= '0;
            level <= ~level;                            // one toggle per period
        end
        else
            count <= count + 1'b1;
    end

    assign stamp     = count;
    assign heartbeat = level;

endmodule

// ==== logic/pretrigger_window.sv ====
`include "capture_macros.svh"

module pretrigger_window (
    input  logic                                         ADA_DCO,
    input  logic                                         hps_fpga_reset_n,
    input  logic                                         shift_en,
    input  sample_pkg::sample_pair_t                     sample,
    output sample_pkg::sample_pair_t [`CAP_PRE_LEN-1:0]  pre  // [0] oldest
);

    sample_pkg::sample_pair_t [`CAP_PRE_LEN-1:0] win;

    ////////////////////////////////////////////////////////////
    // oldest-first shift, held while a record is in flight
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            win <= '0;                                  // zeros show in early records
        end
        else if (shift_en)
        begin
            for (int i = 0; i < `CAP_PRE_LEN - 1; i++)
            begin
                win[i] <= win[i+1];                     // age by one
            end
            win[`CAP_PRE_LEN-1] <= sample;              // newest at top
        end
    end

    // the trigger sample never shifts in, so at commit the
    // window is exactly the four pairs before it

    assign pre = win;

endmodule

// ==== logic/record_buffer.sv ====
`include "capture_macros.svh"

module record_buffer (
    input  logic                                         ADA_DCO,
    input  logic                                         hps_fpga_reset_n,
    input  sample_pkg::sample_pair_t                     sample,
    input  logic                                         post_wr,
    input  logic                                         commit,
    input  logic                                         clear,
    input  sample_pkg::word_idx_t                        post_idx,
    input  sample_pkg::sample_pair_t [`CAP_PRE_LEN-1:0]  pre,
    input  sample_pkg::stamp_t                           stamp,
    input  capture_ctrl_pkg::host_req_t                  host_req,
    output sample_pkg::host_rsp_t                        host_rsp,
    output sample_pkg::rec_idx_t                         record_count,
    output logic                                         buffer_full
);

    localparam int addr_w = $bits(sample_pkg::rec_idx_t) + $bits(sample_pkg::word_idx_t);
    localparam int half_w = `CAP_WORD_W / 2;

    sample_pkg::word_t  mem    [`CAP_NUM_RECORDS * `CAP_REC_WORDS];
    sample_pkg::stamp_t stamps [`CAP_NUM_RECORDS];
    logic [addr_w-1:0]  wr_addr;                        // {record, word}
    logic [addr_w-1:0]  rd_addr;
    logic               rd_req;
    logic               rsp_valid;
    sample_pkg::word_t  rsp_data;
    sample_pkg::stamp_t rsp_stamp;

    // sign-extend each channel into its half word
    function automatic sample_pkg::word_t pack_pair(input sample_pkg::sample_pair_t p);
        logic signed [half_w-1:0] ext_a;
        logic signed [half_w-1:0] ext_b;
        ext_a = p.a;
        ext_b = p.b;
        return {ext_a, ext_b};
    endfunction

    assign wr_addr = {record_count, post_idx};          // 32 words, so concat = rec*32+word
    assign rd_addr = {host_req.record, host_req.word};
    assign rd_req  = host_req.op == capture_ctrl_pkg::OP_READ;

    ////////////////////////////////////////////////////////////
    // record and stamp storage
    always_ff @(posedge ADA_DCO)
    begin
        if (post_wr)
            mem[wr_addr] <= pack_pair(sample);          // words 4..31
        if (commit)
        begin
            for (int i = 0; i < `CAP_PRE_LEN; i++)
            begin
                mem[{record_count, sample_pkg::word_idx_t'(i)}] <= pack_pair(pre[i]);
            end
            stamps[record_count] <= stamp;              // time of commit edge
        end
    end

    // record counter and full flag
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            record_count <= '0;
            buffer_full  <= 1'b0;
        end
        else if (clear)
        begin
            record_count <= '0;
            buffer_full  <= 1'b0;
        end
        else if (commit)
        begin
            record_count <= record_count + 1'b1;
            buffer_full  <= record_count == sample_pkg::rec_idx_t'(`CAP_NUM_RECORDS - 1);
        end
    end

    ////////////////////////////////////////////////////////////
    // host read port, one cycle latency
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_req;                        // pulse per request
    end

    always_ff @(posedge ADA_DCO)
    begin
        if (rd_req && host_req.record < sample_pkg::rec_idx_t'(`CAP_NUM_RECORDS))
        begin
            rsp_data  <= mem[rd_addr];
            rsp_stamp <= stamps[host_req.record];
        end
        else if (rd_req)
        begin
            rsp_data  <= '0;                            // no such record
            rsp_stamp <= '0;
        end
    end

    assign host_rsp = '{valid: rsp_valid, data: rsp_data, stamp: rsp_stamp};

endmodule

// ==== logic/sample_pkg.sv ====
`include "capture_macros.svh"

package sample_pkg;

    // one signed adc sample
    typedef logic signed [`CAP_SAMPLE_W-1:0] sample_t;

    // both channels of one conversion, 28 bits
    typedef struct packed {
        sample_t a;                          // channel a, trigger source
        sample_t b;                          // channel b
    } sample_pair_t;

    // stored word, sign-extended halves
    typedef logic [`CAP_WORD_W-1:0] word_t;

    // record index, counts 0..10 so one spare code
    typedef logic [$clog2(`CAP_NUM_RECORDS+1)-1:0] rec_idx_t;

    // word within a record
    typedef logic [$clog2(`CAP_REC_WORDS)-1:0] word_idx_t;

    // free-running timestamp
    typedef logic [`CAP_TIME_W-1:0] stamp_t;

    // host read response, 59 bits
    typedef struct packed {
        logic   valid;                       // one cycle after OP_READ
        word_t  data;                        // requested word
        stamp_t stamp;                       // stamp of that record
    } host_rsp_t;

endpackage

// ==== logic/trigger_fsm.sv ====
`include "capture_macros.svh"

module trigger_fsm (
    input  logic                       ADA_DCO,
    input  logic                       hps_fpga_reset_n,
    input  sample_pkg::sample_pair_t   sample,
    input  logic                       buffer_full,
    input  capture_ctrl_pkg::host_op_e host_op,
    output logic                       shift_en,     // pre-window advance
    output logic                       post_wr,      // post word write strobe
    output logic                       commit,       // record done
    output logic                       clear,        // buffer reset strobe
    output logic                       capturing,
    output sample_pkg::word_idx_t      post_idx
);

    capture_ctrl_pkg::cap_state_e state;
    sample_pkg::word_idx_t        post_cnt;          // next post word slot
    logic                         below;
    logic                         clear_req;
    logic                         take;

    ////////////////////////////////////////////////////////////
    // decode
    assign below     = sample.a <= `CAP_TRIG_LEVEL;  // signed compare
    assign clear_req = host_op == capture_ctrl_pkg::OP_CLEAR;
    assign clear     = clear_req && (state == capture_ctrl_pkg::IDLE ||
                                     state == capture_ctrl_pkg::FULL);

    // trigger only when idle with room left, clear wins
    assign take = state == capture_ctrl_pkg::IDLE && below && !buffer_full && !clear_req;

    assign shift_en  = state == capture_ctrl_pkg::IDLE && !take;
    assign post_wr   = take || state == capture_ctrl_pkg::CAPTURE;
    assign commit    = state == capture_ctrl_pkg::STORE;
    assign capturing = state == capture_ctrl_pkg::CAPTURE ||
                       state == capture_ctrl_pkg::STORE;

    // trigger sample lands right after the pre words
    assign post_idx = (state == capture_ctrl_pkg::CAPTURE) ? post_cnt
                    : sample_pkg::word_idx_t'(`CAP_PRE_LEN);

    ////////////////////////////////////////////////////////////
    // state register
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            state    <= capture_ctrl_pkg::IDLE;
            post_cnt <= '0;
        end
        else
        begin
            case (state)
                capture_ctrl_pkg::IDLE:
                begin
                    if (take)
                    begin
                        state    <= capture_ctrl_pkg::CAPTURE;
                        post_cnt <= sample_pkg::word_idx_t'(`CAP_PRE_LEN + 1);
                    end
                    else if (buffer_full && !clear)
                        state <= capture_ctrl_pkg::FULL;   // last commit filled it
                end
                capture_ctrl_pkg::CAPTURE:
                begin
                    post_cnt <= post_cnt + 1'b1;
                    if (post_cnt == sample_pkg::word_idx_t'(`CAP_REC_WORDS - 1))
                        state <= capture_ctrl_pkg::STORE;  // word 31 written
                end
                capture_ctrl_pkg::STORE:
                    state <= capture_ctrl_pkg::IDLE;       // sample here dropped
                capture_ctrl_pkg::FULL:
                    if (clear)
                        state <= capture_ctrl_pkg::IDLE;
                default:
                    state <= capture_ctrl_pkg::IDLE;
            endcase
        end
    end

endmodule

// ==== logic/waveform_capture_top.sv ====
`include "capture_macros.svh"

module waveform_capture_top #(
    parameter int unsigned timer_wrap = `CAP_TIMER_WRAP    // heartbeat period
) (
    input  logic                        ADA_DCO,
    input  logic                        hps_fpga_reset_n,
    input  sample_pkg::sample_t         ada_d,             // channel a
    input  sample_pkg::sample_t         adb_d,             // channel b
    input  capture_ctrl_pkg::host_req_t host_req,
    output sample_pkg::host_rsp_t       host_rsp,
    output sample_pkg::rec_idx_t        record_count,
    output logic                        buffer_full,
    output logic                        capturing,
    output logic                        heartbeat
);

    sample_pkg::sample_pair_t                    sample;
    sample_pkg::sample_pair_t [`CAP_PRE_LEN-1:0] pre;
    sample_pkg::word_idx_t                       post_idx;
    sample_pkg::stamp_t                          stamp;
    logic                                        shift_en;
    logic                                        post_wr;
    logic                                        commit;
    logic                                        clear;

    assign sample = '{a: ada_d, b: adb_d};               // bundle both channels

    ////////////////////////////////////////////////////////////
    // sequencer, timebase, pre-window, storage
    trigger_fsm fsm_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .sample(sample), .buffer_full(buffer_full), .host_op(host_req.op),
        .shift_en(shift_en), .post_wr(post_wr), .commit(commit), .clear(clear),
        .capturing(capturing), .post_idx(post_idx));

    capture_timer #(.wrap_count(timer_wrap)) timer_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .stamp(stamp), .heartbeat(heartbeat));

    pretrigger_window window_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .shift_en(shift_en), .sample(sample), .pre(pre));

    record_buffer buffer_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .sample(sample), .post_wr(post_wr), .commit(commit), .clear(clear),
        .post_idx(post_idx), .pre(pre), .stamp(stamp), .host_req(host_req),
        .host_rsp(host_rsp), .record_count(record_count), .buffer_full(buffer_full));

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int period_ns    = 40,             // adc sample clock
    parameter int reset_cycles = 8
) (
    output logic ADA_DCO,
    output logic hps_fpga_reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        ADA_DCO = 1'b0;
        forever #(period_ns / 2) ADA_DCO = ~ADA_DCO;
    end

    // release just after an edge, same skew as the stimulus
    initial
    begin
        hps_fpga_reset_n = 1'b0;
        repeat (reset_cycles) @(posedge ADA_DCO);
        #2 hps_fpga_reset_n = 1'b1;
    end

endmodule

// ==== testbench/tb_waveform_capture.sv ====
`include "capture_macros.svh"

module tb_waveform_capture;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timer_wrap      = 300;               // short heartbeat period
    localparam int num_records     = 12;                // 10 to fill, 2 after clear
    localparam int watchdog_cycles = (num_records + 10) * 40 + 2000;

    logic                        ADA_DCO;
    logic                        hps_fpga_reset_n;
    sample_pkg::sample_t         ada_d;
    sample_pkg::sample_t         adb_d;
    capture_ctrl_pkg::host_req_t host_req;
    sample_pkg::host_rsp_t       host_rsp;
    sample_pkg::rec_idx_t        record_count;
    logic                        buffer_full;
    logic                        capturing;
    logic                        heartbeat;

    int          error_count = 0;
    logic [31:0] rng_state   = 32'hd24db322;

    ////////////////////////////////////////////////////////////
    // reference model state
    capture_ctrl_pkg::cap_state_e m_state = capture_ctrl_pkg::IDLE;
    sample_pkg::sample_pair_t     m_pre [`CAP_PRE_LEN];  // [0] oldest
    sample_pkg::word_t            m_mem [`CAP_NUM_RECORDS][`CAP_REC_WORDS];
    sample_pkg::stamp_t           m_stamp [`CAP_NUM_RECORDS];
    int                           m_commit_cyc [`CAP_NUM_RECORDS];
    sample_pkg::stamp_t           rd_stamp [`CAP_NUM_RECORDS];   // as read back
    int                           m_post  = 0;
    int                           m_count = 0;
    bit                           m_full  = 1'b0;
    int                           m_timer = 0;
    bit                           m_hb    = 1'b0;
    int                           m_cycle = 0;           // edges since reset
    bit                           exp_valid = 1'b0;
    sample_pkg::word_t            exp_data;
    sample_pkg::stamp_t           exp_stamp;

    tb_clock_gen #(.period_ns(40), .reset_cycles(8)) clock_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n));

    waveform_capture_top #(.timer_wrap(timer_wrap)) dut_i (
        .ADA_DCO(ADA_DCO), .hps_fpga_reset_n(hps_fpga_reset_n),
        .ada_d(ada_d), .adb_d(adb_d), .host_req(host_req), .host_rsp(host_rsp),
        .record_count(record_count), .buffer_full(buffer_full),
        .capturing(capturing), .heartbeat(heartbeat));

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // mostly above threshold, 1 in 60 at or below, some right at the edge
    function automatic sample_pkg::sample_t random_a();
        logic [31:0] r;
        int          k;
        int          v;
        r = lcg_next();
        k = int'(r[31:16]) % 120;
        if (k == 0)
            v = -2170;                                  // exactly on threshold
        else if (k == 1)
            v = -8192 + int'(r[15:0]) % 6023;           // deep pulse
        else if (k < 4)
            v = -2169;                                  // one lsb short
        else
            v = -2169 + int'(r[15:0]) % 10361;
        return sample_pkg::sample_t'(v);
    endfunction

    // a in upper half, b in lower, both sign-extended
    function automatic sample_pkg::word_t pack_word(input sample_pkg::sample_pair_t p);
        return {{2{p.a[13]}}, p.a, {2{p.b[13]}}, p.b};
    endfunction

    task automatic shift_pre(input sample_pkg::sample_pair_t p);
        for (int i = 0; i < `CAP_PRE_LEN - 1; i++)
            m_pre[i] = m_pre[i+1];
        m_pre[`CAP_PRE_LEN-1] = p;
    endtask

    ////////////////////////////////////////////////////////////
    // one rising edge of the model, using the inputs now applied
    task automatic model_step();
        sample_pkg::sample_pair_t s;
        sample_pkg::stamp_t       now_stamp;
        bit                       clr;
        s         = '{a: ada_d, b: adb_d};
        now_stamp = sample_pkg::stamp_t'(m_timer);
        clr       = host_req.op == capture_ctrl_pkg::OP_CLEAR;
        exp_valid = host_req.op == capture_ctrl_pkg::OP_READ;
        if (exp_valid)
        begin
            exp_data  = m_mem[host_req.record][host_req.word];   // old contents
            exp_stamp = m_stamp[host_req.record];
        end
        case (m_state)
            capture_ctrl_pkg::IDLE:
            begin
                if (clr)
                begin
                    m_count = 0;
                    m_full  = 1'b0;
                    shift_pre(s);
                end
                else if (s.a <= -2170 && !m_full)
                begin
                    m_mem[m_count][`CAP_PRE_LEN] = pack_word(s);   // trigger word
                    m_post  = `CAP_PRE_LEN + 1;
                    m_state = capture_ctrl_pkg::CAPTURE;
                end
                else
                begin
                    shift_pre(s);
                    if (m_full)
                        m_state = capture_ctrl_pkg::FULL;
                end
            end
            capture_ctrl_pkg::CAPTURE:
            begin
                m_mem[m_count][m_post] = pack_word(s);
                if (m_post == `CAP_REC_WORDS - 1)
                    m_state = capture_ctrl_pkg::STORE;
                m_post++;
            end
            capture_ctrl_pkg::STORE:
            begin
                for (int i = 0; i < `CAP_PRE_LEN; i++)
                    m_mem[m_count][i] = pack_word(m_pre[i]);
                m_stamp[m_count]      = now_stamp;
                m_commit_cyc[m_count] = m_cycle;
                m_count++;
                m_full  = m_count == `CAP_NUM_RECORDS;
                m_state = capture_ctrl_pkg::IDLE;        // this sample dropped
            end
            default:
            begin
                if (clr)
                begin
                    m_count = 0;
                    m_full  = 1'b0;
                    m_state = capture_ctrl_pkg::IDLE;
                end
            end
        endcase
        if (m_timer == timer_wrap - 1)
        begin
            m_timer = 0;
            m_hb    = !m_hb;
        end
        else
            m_timer++;
        m_cycle++;
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            error_count++;
            $display("ERROR %s: got %h, expected %h (cycle %0d)", name, got, exp, m_cycle);
        end
    endtask

    task automatic check_outputs();
        compare_value("record_count", record_count, m_count);
        compare_value("buffer_full", buffer_full, m_full);
        compare_value("capturing", capturing, m_state == capture_ctrl_pkg::CAPTURE ||
                                              m_state == capture_ctrl_pkg::STORE);
        compare_value("heartbeat", heartbeat, m_hb);
        compare_value("host_rsp.valid", host_rsp.valid, exp_valid);
        if (exp_valid)
        begin
            compare_value("host_rsp.data", host_rsp.data, exp_data);
            compare_value("host_rsp.stamp", host_rsp.stamp, exp_stamp);
        end
    endtask

    // edge, check, then drive the next inputs
    task automatic run_cycle(input capture_ctrl_pkg::host_op_e op, input int rec,
                             input int word);
        @(posedge ADA_DCO);
        #2;
        model_step();
        check_outputs();
        host_req = '{op: op, record: sample_pkg::rec_idx_t'(rec),
                     word: sample_pkg::word_idx_t'(word)};
        ada_d = random_a();
        adb_d = sample_pkg::sample_t'(lcg_next() >> 18);
        if (m_cycle == 1)
            ada_d = -2169;                              // must not trigger
        else if (m_cycle == 2)
            ada_d = -2170;                              // early trigger, zeros in pre
    endtask

    task automatic read_records(input int first, input int last);
        for (int r = first; r <= last; r++)
        begin
            for (int w = 0; w < `CAP_REC_WORDS; w++)
            begin
                run_cycle(capture_ctrl_pkg::OP_READ, r, w);
                if (w == 1)
                    rd_stamp[r] = host_rsp.stamp;       // answer to word 0
            end
        end
        run_cycle(capture_ctrl_pkg::OP_NOP, 0, 0);      // last response
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    initial
    begin
        ada_d    = '0;
        adb_d    = '0;
        host_req = '{op: capture_ctrl_pkg::OP_NOP, record: '0, word: '0};
        for (int i = 0; i < `CAP_PRE_LEN; i++)
            m_pre[i] = '0;
        @(posedge hps_fpga_reset_n);
        check_outputs();                                // reset values

        while (m_state != capture_ctrl_pkg::FULL)
            run_cycle(capture_ctrl_pkg::OP_NOP, 0, 0);
        repeat (100) run_cycle(capture_ctrl_pkg::OP_NOP, 0, 0);   // triggers ignored
        read_records(0, `CAP_NUM_RECORDS - 1);

        // stamp spacing against commit spacing
        for (int r = 1; r < `CAP_NUM_RECORDS; r++)
            compare_value("stamp delta",
                (int'(rd_stamp[r]) + timer_wrap - int'(rd_stamp[r-1])) % timer_wrap,
                (m_commit_cyc[r] - m_commit_cyc[r-1]) % timer_wrap);

        run_cycle(capture_ctrl_pkg::OP_CLEAR, 0, 0);
        run_cycle(capture_ctrl_pkg::OP_NOP, 0, 0);
        compare_value("record_count", record_count, 0);
        while (m_count < 2)
            run_cycle(capture_ctrl_pkg::OP_NOP, 0, 0);
        read_records(0, 1);                             // record 0 rewritten

        $display("run complete: %0d errors in %0d cycles", error_count, m_cycle);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        #(watchdog_cycles * 40);
        $display("timeout: run did not finish in %0d cycles, %0d errors so far",
                 watchdog_cycles, error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
